// File: src/rv_dec_pkg.sv
package rv_dec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // base opcodes, rv32im subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra, srai
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // group field at the top of the decode word
    localparam logic [2:0] GRP_NONE   = 3'd0;
    localparam logic [2:0] GRP_ALU    = 3'd1;
    localparam logic [2:0] GRP_BJP    = 3'd2;
    localparam logic [2:0] GRP_MULDIV = 3'd3;
    localparam logic [2:0] GRP_MEM    = 3'd4;

    localparam int DEC_PAYLOAD_W = 14;
    localparam int DEC_INFO_W    = 17;

    typedef struct packed {
        logic [2:0] grp;
        logic lui, auipc, add, sub, sll, slt, sltu;
        logic xor_op, srl, sra, or_op, and_op;
        logic op2imm;  // second operand is the immediate
        logic op1pc;   // first operand is the pc
    } alu_info_t;

    typedef struct packed {
        logic [2:0] grp;
        logic jump, beq, bne, blt, bge, bltu, bgeu;
        logic op1rs1;  // jalr target base is rs1
        logic [DEC_PAYLOAD_W-9:0] pad;
    } bjp_info_t;

    typedef struct packed {
        logic [2:0] grp;
        logic mul, mulh, mulhsu, mulhu, div, divu, rem, remu;
        logic op_mul, op_div;
        logic [DEC_PAYLOAD_W-11:0] pad;
    } muldiv_info_t;

    typedef struct packed {
        logic [2:0] grp;
        logic lb, lh, lw, lbu, lhu, sb, sh, sw;
        logic op_load, op_store;
        logic [DEC_PAYLOAD_W-11:0] pad;
    } mem_info_t;

    // one word, payload meaning picked by grp
    typedef union packed {
        alu_info_t    alu;
        bjp_info_t    bjp;
        muldiv_info_t muldiv;
        mem_info_t    mem;
    } dec_info_u;

    localparam int EX_CLASS_W = 3;

    localparam logic [EX_CLASS_W-1:0] EX_OTHER = 3'd0; // stores and illegal too
    localparam logic [EX_CLASS_W-1:0] EX_ALU   = 3'd1;
    localparam logic [EX_CLASS_W-1:0] EX_MUL   = 3'd2;
    localparam logic [EX_CLASS_W-1:0] EX_DIV   = 3'd3;
    localparam logic [EX_CLASS_W-1:0] EX_BJP   = 3'd4;
    localparam logic [EX_CLASS_W-1:0] EX_LOAD  = 3'd5;

endpackage

// File: src/inst_classify.sv
`timescale 1ns/100ps

module inst_classify #(
    parameter bit MULDIV_EN = 1'b1
) (
    input  logic [rv_dec_pkg::XLEN-1:0]       inst_i,
    output rv_dec_pkg::dec_info_u             info_o,
    output logic [rv_dec_pkg::EX_CLASS_W-1:0] ex_class_o,
    output logic                              illegal_o
);

    wire [6:0] opcode = inst_i[6:0];
    wire [6:0] funct7 = inst_i[31:25];
    wire [7:0] f3     = 8'b1 << inst_i[14:12]; // one-hot funct3

    wire is_opimm  = (opcode == rv_dec_pkg::OPC_OP_IMM);
    wire is_op     = (opcode == rv_dec_pkg::OPC_OP);
    wire is_branch = (opcode == rv_dec_pkg::OPC_BRANCH);
    wire is_load   = (opcode == rv_dec_pkg::OPC_LOAD);
    wire is_store  = (opcode == rv_dec_pkg::OPC_STORE);
    wire is_lui    = (opcode == rv_dec_pkg::OPC_LUI);
    wire is_auipc  = (opcode == rv_dec_pkg::OPC_AUIPC);
    wire is_jal    = (opcode == rv_dec_pkg::OPC_JAL);
    wire is_jalr   = (opcode == rv_dec_pkg::OPC_JALR) & f3[0];

    wire f7_base = (funct7 == rv_dec_pkg::F7_BASE);
    wire f7_alt  = (funct7 == rv_dec_pkg::F7_ALT);
    wire f7_md   = (funct7 == rv_dec_pkg::F7_MULDIV);

    wire r_base = is_op & f7_base;
    wire r_md   = is_op & f7_md & MULDIV_EN; // m extension gate

    wire slli = is_opimm & f3[1] & f7_base;
    wire srli = is_opimm & f3[5] & f7_base;
    wire srai = is_opimm & f3[5] & f7_alt;
    wire imm_nonshift = is_opimm & ~(f3[1] | f3[5]);

    wire sub = is_op & f7_alt & f3[0];
    wire sra = is_op & f7_alt & f3[5];

    wire br_ok    = is_branch & ~(f3[2] | f3[3]);
    wire load_ok  = is_load & (f3[0] | f3[1] | f3[2] | f3[4] | f3[5]);
    wire store_ok = is_store & (f3[0] | f3[1] | f3[2]);

    wire type_mul = r_md & ~inst_i[14];
    wire type_div = r_md & inst_i[14];

    wire sel_alu = is_lui | is_auipc | imm_nonshift | slli | srli | srai | r_base | sub | sra;
    wire sel_bjp = is_jal | is_jalr | br_ok;
    wire sel_mem = load_ok | store_ok;

    wire shamt_bad = is_opimm & (f3[1] | f3[5]) & f7_md; // slli/srli with m funct7

    rv_dec_pkg::dec_info_u alu_w, bjp_w, md_w, mem_w;

    always_comb begin
        alu_w = '0;
        alu_w.alu.grp    = rv_dec_pkg::GRP_ALU;
        alu_w.alu.lui    = is_lui;
        alu_w.alu.auipc  = is_auipc;
        alu_w.alu.add    = (is_opimm & f3[0]) | (r_base & f3[0]); // nop lands here
        alu_w.alu.sub    = sub;
        alu_w.alu.sll    = slli | (r_base & f3[1]);
        alu_w.alu.slt    = (is_opimm & f3[2]) | (r_base & f3[2]);
        alu_w.alu.sltu   = (is_opimm & f3[3]) | (r_base & f3[3]);
        alu_w.alu.xor_op = (is_opimm & f3[4]) | (r_base & f3[4]);
        alu_w.alu.srl    = srli | (r_base & f3[5]);
        alu_w.alu.sra    = srai | sra;
        alu_w.alu.or_op  = (is_opimm & f3[6]) | (r_base & f3[6]);
        alu_w.alu.and_op = (is_opimm & f3[7]) | (r_base & f3[7]);
        alu_w.alu.op2imm = is_opimm | is_lui | is_auipc;
        alu_w.alu.op1pc  = is_auipc;

        bjp_w = '0;
        bjp_w.bjp.grp    = rv_dec_pkg::GRP_BJP;
        bjp_w.bjp.jump   = is_jal | is_jalr;
        bjp_w.bjp.beq    = is_branch & f3[0];
        bjp_w.bjp.bne    = is_branch & f3[1];
        bjp_w.bjp.blt    = is_branch & f3[4];
        bjp_w.bjp.bge    = is_branch & f3[5];
        bjp_w.bjp.bltu   = is_branch & f3[6];
        bjp_w.bjp.bgeu   = is_branch & f3[7];
        bjp_w.bjp.op1rs1 = is_jalr;

        md_w = '0;
        md_w.muldiv.grp    = rv_dec_pkg::GRP_MULDIV;
        {md_w.muldiv.mul, md_w.muldiv.mulh, md_w.muldiv.mulhsu, md_w.muldiv.mulhu}
            = {4{r_md}} & {f3[0], f3[1], f3[2], f3[3]};
        {md_w.muldiv.div, md_w.muldiv.divu, md_w.muldiv.rem, md_w.muldiv.remu}
            = {4{r_md}} & {f3[4], f3[5], f3[6], f3[7]};
        md_w.muldiv.op_mul = type_mul;
        md_w.muldiv.op_div = type_div;

        mem_w = '0;
        mem_w.mem.grp      = rv_dec_pkg::GRP_MEM;
        {mem_w.mem.lb, mem_w.mem.lh, mem_w.mem.lw, mem_w.mem.lbu, mem_w.mem.lhu}
            = {5{is_load}} & {f3[0], f3[1], f3[2], f3[4], f3[5]};
        {mem_w.mem.sb, mem_w.mem.sh, mem_w.mem.sw} = {3{is_store}} & {f3[0], f3[1], f3[2]};
        mem_w.mem.op_load  = load_ok;
        mem_w.mem.op_store = store_ok;
    end

    // at most one select is high, none gives GRP_NONE
    assign info_o = ({rv_dec_pkg::DEC_INFO_W{sel_alu}} & alu_w)
                  | ({rv_dec_pkg::DEC_INFO_W{sel_bjp}} & bjp_w)
                  | ({rv_dec_pkg::DEC_INFO_W{r_md}}    & md_w)
                  | ({rv_dec_pkg::DEC_INFO_W{sel_mem}} & mem_w);

    assign ex_class_o = sel_alu  ? rv_dec_pkg::EX_ALU  :
                        type_mul ? rv_dec_pkg::EX_MUL  :
                        type_div ? rv_dec_pkg::EX_DIV  :
                        sel_bjp  ? rv_dec_pkg::EX_BJP  :
                        load_ok  ? rv_dec_pkg::EX_LOAD :
                                   rv_dec_pkg::EX_OTHER;

    assign illegal_o = (info_o.alu.grp == rv_dec_pkg::GRP_NONE) | shamt_bad;

endmodule

// File: src/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
    input  logic [rv_dec_pkg::XLEN-1:0] inst_i,
    output logic [rv_dec_pkg::XLEN-1:0] imm_o
);

    localparam int XLEN = rv_dec_pkg::XLEN;

    logic [6:0]      opcode;
    logic            shift_imm;
    logic [XLEN-1:0] imm_i_type;

    assign opcode     = inst_i[6:0];
    assign shift_imm  = (inst_i[13:12] == 2'b01); // funct3 001 or 101
    assign imm_i_type = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};

    always_comb begin
        case (opcode)
            rv_dec_pkg::OPC_LUI,
            rv_dec_pkg::OPC_AUIPC:  imm_o = {inst_i[31:12], 12'b0};
            rv_dec_pkg::OPC_JAL:    imm_o = {{(XLEN-20){inst_i[31]}}, inst_i[19:12],
                                             inst_i[20], inst_i[30:21], 1'b0};
            rv_dec_pkg::OPC_JALR,
            rv_dec_pkg::OPC_LOAD:   imm_o = imm_i_type;
            rv_dec_pkg::OPC_OP_IMM: begin
                // shamt only, upper bits belong to funct7
                imm_o = shift_imm ? {{(XLEN-5){1'b0}}, inst_i[24:20]} : imm_i_type;
            end
            rv_dec_pkg::OPC_BRANCH: imm_o = {{(XLEN-12){inst_i[31]}}, inst_i[7],
                                             inst_i[30:25], inst_i[11:8], 1'b0};
            rv_dec_pkg::OPC_STORE:  imm_o = {{(XLEN-12){inst_i[31]}}, inst_i[31:25],
                                             inst_i[11:7]};
            default:                imm_o = '0;
        endcase
    end

endmodule

// File: src/reg_access.sv
`timescale 1ns/100ps

module reg_access (
    input  logic [rv_dec_pkg::XLEN-1:0]       inst_i,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic                              rs1_re_o,
    output logic                              rs2_re_o,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                              rd_write_o
);

    wire [6:0] opcode = inst_i[6:0];
    wire [rv_dec_pkg::REG_ADDR_W-1:0] rd  = inst_i[11:7];
    wire [rv_dec_pkg::REG_ADDR_W-1:0] rs1 = inst_i[19:15];
    wire [rv_dec_pkg::REG_ADDR_W-1:0] rs2 = inst_i[24:20];

    // u-type and jal carry no rs1 field
    wire use_rs1 = ~((opcode == rv_dec_pkg::OPC_LUI) | (opcode == rv_dec_pkg::OPC_AUIPC)
                   | (opcode == rv_dec_pkg::OPC_JAL));
    wire use_rs2 = (opcode == rv_dec_pkg::OPC_OP) | (opcode == rv_dec_pkg::OPC_STORE)
                 | (opcode == rv_dec_pkg::OPC_BRANCH);

    wire use_rd = (opcode == rv_dec_pkg::OPC_LUI)  | (opcode == rv_dec_pkg::OPC_AUIPC)
                | (opcode == rv_dec_pkg::OPC_JAL)  | (opcode == rv_dec_pkg::OPC_JALR)
                | (opcode == rv_dec_pkg::OPC_LOAD) | (opcode == rv_dec_pkg::OPC_OP_IMM)
                | (opcode == rv_dec_pkg::OPC_OP);

    assign rs1_addr_o = use_rs1 ? rs1 : '0;
    assign rs2_addr_o = use_rs2 ? rs2 : '0;
    assign rs1_re_o   = use_rs1 && (rs1 != '0); // x0 needs no port
    assign rs2_re_o   = use_rs2 && (rs2 != '0);

    assign rd_write_o = use_rd && (rd != '0);
    assign rd_addr_o  = rd_write_o ? rd : '0;

endmodule

// File: src/id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              valid_i,
    input  logic [rv_dec_pkg::XLEN-1:0]       inst_addr_i,
    input  rv_dec_pkg::dec_info_u             info_i,
    input  logic [rv_dec_pkg::EX_CLASS_W-1:0] ex_class_i,
    input  logic                              illegal_i,
    input  logic [rv_dec_pkg::XLEN-1:0]       imm_i,
    input  logic [rv_dec_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic                              rd_write_i,
    output logic                              valid_o,
    output logic [rv_dec_pkg::XLEN-1:0]       inst_addr_o,
    output rv_dec_pkg::dec_info_u             info_o,
    output logic [rv_dec_pkg::EX_CLASS_W-1:0] ex_class_o,
    output logic                              illegal_o,
    output logic [rv_dec_pkg::XLEN-1:0]       imm_o,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] rd_waddr_o,
    output logic                              reg_we_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o     <= 1'b0;
            illegal_o   <= 1'b0;
            reg_we_o    <= 1'b0;
            inst_addr_o <= '0;
            info_o      <= '0;
            ex_class_o  <= '0;
            imm_o       <= '0;
            rd_waddr_o  <= '0;
        end else begin
            valid_o   <= valid_i;
            illegal_o <= valid_i & illegal_i;
            reg_we_o  <= valid_i & ~illegal_i & rd_write_i; // no write-back on a trap
            if (valid_i) begin
                inst_addr_o <= inst_addr_i;
                info_o      <= info_i;
                ex_class_o  <= ex_class_i;
                imm_o       <= imm_i;
                rd_waddr_o  <= rd_addr_i;
            end
        end
    end

endmodule

// File: src/idu_top.sv
`timescale 1ns/100ps

module idu_top #(
    parameter bit MULDIV_EN = 1'b1
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [rv_dec_pkg::XLEN-1:0]       inst_i,
    input  logic [rv_dec_pkg::XLEN-1:0]       inst_addr_i,
    input  logic                              inst_valid_i,
    // register file read side, same cycle
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] reg1_raddr_o,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] reg2_raddr_o,
    output logic                              rs1_re_o,
    output logic                              rs2_re_o,
    // to execute, one cycle later
    output logic                              valid_o,
    output logic [rv_dec_pkg::XLEN-1:0]       inst_addr_o,
    output logic [rv_dec_pkg::XLEN-1:0]       imm_o,
    output rv_dec_pkg::dec_info_u             info_o,
    output logic [rv_dec_pkg::EX_CLASS_W-1:0] ex_class_o,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] rd_waddr_o,
    output logic                              reg_we_o,
    output logic                              illegal_o
);

    rv_dec_pkg::dec_info_u             info;
    logic [rv_dec_pkg::EX_CLASS_W-1:0] ex_class;
    logic                              illegal_raw; // not yet qualified by valid
    logic [rv_dec_pkg::XLEN-1:0]       imm;
    logic [rv_dec_pkg::REG_ADDR_W-1:0] rd_addr;
    logic                              rd_write;

    inst_classify #(
        .MULDIV_EN (MULDIV_EN)
    ) u_classify (
        .inst_i     (inst_i),
        .info_o     (info),
        .ex_class_o (ex_class),
        .illegal_o  (illegal_raw)
    );

    imm_gen u_imm_gen (
        .inst_i (inst_i),
        .imm_o  (imm)
    );

    reg_access u_reg_access (
        .inst_i     (inst_i),
        .rs1_addr_o (reg1_raddr_o),
        .rs2_addr_o (reg2_raddr_o),
        .rs1_re_o   (rs1_re_o),
        .rs2_re_o   (rs2_re_o),
        .rd_addr_o  (rd_addr),
        .rd_write_o (rd_write)
    );

    id_ex_reg u_id_ex_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (inst_valid_i),
        .inst_addr_i (inst_addr_i),
        .info_i      (info),
        .ex_class_i  (ex_class),
        .illegal_i   (illegal_raw),
        .imm_i       (imm),
        .rd_addr_i   (rd_addr),
        .rd_write_i  (rd_write),
        .valid_o     (valid_o),
        .inst_addr_o (inst_addr_o),
        .info_o      (info_o),
        .ex_class_o  (ex_class_o),
        .illegal_o   (illegal_o),
        .imm_o       (imm_o),
        .rd_waddr_o  (rd_waddr_o),
        .reg_we_o    (reg_we_o)
    );

endmodule

// File: dv/idu_props.sv
`timescale 1ns/100ps

module idu_props (
    input logic                              clk,
    input logic                              reset_i,
    input logic                              valid_i,
    input logic                              reg_we_i,
    input logic                              illegal_i,
    input logic [rv_dec_pkg::REG_ADDR_W-1:0] rd_waddr_i
);

    int unsigned fail_count = 0; // failed assertions so far

    // write-back only for a legal, valid slot
    we_legal: assert property (@(posedge clk) disable iff (reset_i)
        reg_we_i |-> (valid_i && !illegal_i))
        else begin
            $error("reg_we_o high without a legal valid instruction");
            fail_count++;
        end

    ill_valid: assert property (@(posedge clk) disable iff (reset_i)
        illegal_i |-> valid_i)
        else begin
            $error("illegal_o high on an empty slot");
            fail_count++;
        end

    we_not_x0: assert property (@(posedge clk) disable iff (reset_i)
        reg_we_i |-> (rd_waddr_i != '0)) // x0 is never written
        else begin
            $error("reg_we_o high with rd_waddr_o equal to zero");
            fail_count++;
        end

endmodule

bind idu_top idu_props u_props (
    .clk        (clk),
    .reset_i    (reset_i),
    .valid_i    (valid_o),
    .reg_we_i   (reg_we_o),
    .illegal_i  (illegal_o),
    .rd_waddr_i (rd_waddr_o)
);

// File: dv/tb_idu.sv
`timescale 1ns/100ps

module tb_idu;

    localparam bit          MULDIV_EN    = 1'b1;
    localparam int          NUM_INSTS    = 2000;
    localparam int          RESET_CYCLES = 4;
    localparam int          MAX_CYCLES   = 4 * NUM_INSTS;
    localparam logic [31:0] RAND_SEED    = 32'h000f_6c4a;
    localparam logic [6:0]  OPC_SYSTEM   = 7'b1110011; // ecall, ebreak, csr ops
    localparam logic [6:0]  OPC_FENCE    = 7'b0001111;

    logic                  clk;
    logic                  reset_i;
    logic [31:0]           inst_i;
    logic [31:0]           inst_addr_i;
    logic                  inst_valid_i;
    logic [4:0]            reg1_raddr_o, reg2_raddr_o;
    logic                  rs1_re_o, rs2_re_o;
    logic                  valid_o, reg_we_o, illegal_o;
    logic [31:0]           inst_addr_o, imm_o;
    rv_dec_pkg::dec_info_u info_o;
    logic [2:0]            ex_class_o;
    logic [4:0]            rd_waddr_o;

    // decode of the word driven this cycle
    logic                  cur_valid, cur_ill, cur_re1, cur_re2, cur_wr;
    logic [31:0]           cur_inst, cur_addr, cur_imm;
    logic [2:0]            cur_cls;
    logic [4:0]            cur_ra1, cur_ra2, cur_rd;
    rv_dec_pkg::dec_info_u cur_info;
    // expected contents of the decode-to-execute register
    logic                  exp_valid, exp_ill, exp_we;
    logic [31:0]           exp_addr, exp_imm;
    logic [2:0]            exp_cls;
    logic [4:0]            exp_rd;
    rv_dec_pkg::dec_info_u exp_info;

    idu_top #(
        .MULDIV_EN (MULDIV_EN)
    ) DUT (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_assertions();
        if (DUT.u_props.fail_count != 0) begin
            $display("error: time %0t a bound assertion on the outputs failed", $time);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not happen within the cycle limit", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] random_inst();
        logic [31:0] word;
        int unsigned pick;
        word = $urandom();
        pick = $urandom_range(99);
        if (pick < 75) begin
            case ($urandom_range(8))
                0: word[6:0] = rv_dec_pkg::OPC_LUI;
                1: word[6:0] = rv_dec_pkg::OPC_AUIPC;
                2: word[6:0] = rv_dec_pkg::OPC_JAL;
                3: word[6:0] = rv_dec_pkg::OPC_JALR;
                4: word[6:0] = rv_dec_pkg::OPC_BRANCH;
                5: word[6:0] = rv_dec_pkg::OPC_LOAD;
                6: word[6:0] = rv_dec_pkg::OPC_STORE;
                7: word[6:0] = rv_dec_pkg::OPC_OP_IMM;
                default: word[6:0] = rv_dec_pkg::OPC_OP;
            endcase
            case ($urandom_range(3))
                0: word[31:25] = rv_dec_pkg::F7_BASE;
                1: word[31:25] = rv_dec_pkg::F7_ALT;
                2: word[31:25] = rv_dec_pkg::F7_MULDIV;
                default: ; // keep random funct7
            endcase
            if ($urandom_range(7) == 0) begin
                word[11:7] = 5'd0; // rd x0, nop style
            end
            if ($urandom_range(7) == 0) begin
                word[19:15] = 5'd0;
            end
        end else if (pick < 85) begin
            word[6:0] = word[31] ? OPC_SYSTEM : OPC_FENCE; // dropped groups
        end
        return word;
    endfunction

    task automatic decode_model(input logic [31:0] inst, output rv_dec_pkg::dec_info_u info,
                                output logic [2:0] cls, output logic ill);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alu_f3;
        logic       imm_op;
        f3 = inst[14:12];
        f7 = inst[31:25];
        info = '0;
        ill = 1'b0;
        alu_f3 = 1'b0;
        imm_op = 1'b0;
        case (inst[6:0])
            rv_dec_pkg::OPC_LUI: begin
                info.alu.grp = rv_dec_pkg::GRP_ALU;
                info.alu.lui = 1'b1;
                info.alu.op2imm = 1'b1;
            end
            rv_dec_pkg::OPC_AUIPC: begin
                info.alu.grp = rv_dec_pkg::GRP_ALU;
                info.alu.auipc = 1'b1;
                info.alu.op2imm = 1'b1;
                info.alu.op1pc = 1'b1;
            end
            rv_dec_pkg::OPC_OP_IMM: begin
                imm_op = 1'b1;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    alu_f3 = (f7 == rv_dec_pkg::F7_BASE)
                           || (f3 == 3'd5 && f7 == rv_dec_pkg::F7_ALT);
                    ill = (f7 == rv_dec_pkg::F7_MULDIV);
                end else begin
                    alu_f3 = 1'b1;
                end
            end
            rv_dec_pkg::OPC_OP: begin
                alu_f3 = (f7 == rv_dec_pkg::F7_BASE)
                       || (f7 == rv_dec_pkg::F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
                if (f7 == rv_dec_pkg::F7_MULDIV && MULDIV_EN) begin
                    info.muldiv.grp = rv_dec_pkg::GRP_MULDIV;
                    {info.muldiv.mul, info.muldiv.mulh, info.muldiv.mulhsu, info.muldiv.mulhu,
                     info.muldiv.div, info.muldiv.divu, info.muldiv.rem, info.muldiv.remu}
                        = 8'b1000_0000 >> f3;
                    info.muldiv.op_mul = !f3[2];
                    info.muldiv.op_div = f3[2];
                end
            end
            rv_dec_pkg::OPC_JAL: begin
                info.bjp.grp = rv_dec_pkg::GRP_BJP;
                info.bjp.jump = 1'b1;
            end
            rv_dec_pkg::OPC_JALR: begin
                if (f3 == 3'd0) begin
                    info.bjp.grp = rv_dec_pkg::GRP_BJP;
                    info.bjp.jump = 1'b1;
                    info.bjp.op1rs1 = 1'b1;
                end
            end
            rv_dec_pkg::OPC_BRANCH: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    info.bjp.grp = rv_dec_pkg::GRP_BJP;
                    case (f3)
                        3'd0: info.bjp.beq = 1'b1;
                        3'd1: info.bjp.bne = 1'b1;
                        3'd4: info.bjp.blt = 1'b1;
                        3'd5: info.bjp.bge = 1'b1;
                        3'd6: info.bjp.bltu = 1'b1;
                        default: info.bjp.bgeu = 1'b1;
                    endcase
                end
            end
            rv_dec_pkg::OPC_LOAD: begin
                if (f3 != 3'd3 && f3 < 3'd6) begin
                    info.mem.grp = rv_dec_pkg::GRP_MEM;
                    info.mem.op_load = 1'b1;
                    case (f3)
                        3'd0: info.mem.lb = 1'b1;
                        3'd1: info.mem.lh = 1'b1;
                        3'd2: info.mem.lw = 1'b1;
                        3'd4: info.mem.lbu = 1'b1;
                        default: info.mem.lhu = 1'b1;
                    endcase
                end
            end
            rv_dec_pkg::OPC_STORE: begin
                if (f3 < 3'd3) begin
                    info.mem.grp = rv_dec_pkg::GRP_MEM;
                    info.mem.op_store = 1'b1;
                    {info.mem.sb, info.mem.sh, info.mem.sw} = 3'b100 >> f3;
                end
            end
            default: ;
        endcase
        if (alu_f3) begin
            info.alu.grp = rv_dec_pkg::GRP_ALU;
            info.alu.op2imm = imm_op;
            case (f3)
                3'd0: begin
                    if (f7 == rv_dec_pkg::F7_ALT && !imm_op) begin
                        info.alu.sub = 1'b1;
                    end else begin
                        info.alu.add = 1'b1;
                    end
                end
                3'd1: info.alu.sll = 1'b1;
                3'd2: info.alu.slt = 1'b1;
                3'd3: info.alu.sltu = 1'b1;
                3'd4: info.alu.xor_op = 1'b1;
                3'd5: begin
                    if (f7 == rv_dec_pkg::F7_ALT) begin
                        info.alu.sra = 1'b1;
                    end else begin
                        info.alu.srl = 1'b1;
                    end
                end
                3'd6: info.alu.or_op = 1'b1;
                default: info.alu.and_op = 1'b1;
            endcase
        end
        ill = ill || (info.alu.grp == rv_dec_pkg::GRP_NONE);
        case (info.alu.grp)
            rv_dec_pkg::GRP_ALU:    cls = rv_dec_pkg::EX_ALU;
            rv_dec_pkg::GRP_MULDIV: cls = f3[2] ? rv_dec_pkg::EX_DIV : rv_dec_pkg::EX_MUL;
            rv_dec_pkg::GRP_BJP:    cls = rv_dec_pkg::EX_BJP;
            rv_dec_pkg::GRP_MEM:    cls = info.mem.op_load ? rv_dec_pkg::EX_LOAD
                                                           : rv_dec_pkg::EX_OTHER;
            default:                cls = rv_dec_pkg::EX_OTHER;
        endcase
    endtask

    function automatic logic [31:0] imm_model(input logic [31:0] inst);
        logic [31:0] imm;
        imm = '0;
        case (inst[6:0])
            rv_dec_pkg::OPC_LUI, rv_dec_pkg::OPC_AUIPC: imm = {inst[31:12], 12'h000};
            rv_dec_pkg::OPC_JAL:
                imm = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
            rv_dec_pkg::OPC_JALR, rv_dec_pkg::OPC_LOAD: imm = $signed(inst[31:20]);
            rv_dec_pkg::OPC_OP_IMM: begin
                if (inst[14:12] == 3'd1 || inst[14:12] == 3'd5) begin
                    imm = {27'd0, inst[24:20]}; // shamt
                end else begin
                    imm = $signed(inst[31:20]);
                end
            end
            rv_dec_pkg::OPC_BRANCH:
                imm = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
            rv_dec_pkg::OPC_STORE: imm = $signed({inst[31:25], inst[11:7]});
            default: ;
        endcase
        return imm;
    endfunction

    task automatic reg_model(input logic [31:0] inst, output logic [4:0] ra1,
                             output logic [4:0] ra2, output logic re1, output logic re2,
                             output logic [4:0] rda, output logic wr);
        logic use1;
        logic use2;
        logic use_rd;
        use1 = 1'b1;
        use2 = 1'b0;
        use_rd = 1'b0;
        case (inst[6:0])
            rv_dec_pkg::OPC_LUI, rv_dec_pkg::OPC_AUIPC, rv_dec_pkg::OPC_JAL: begin
                use1 = 1'b0;
                use_rd = 1'b1;
            end
            rv_dec_pkg::OPC_JALR, rv_dec_pkg::OPC_LOAD, rv_dec_pkg::OPC_OP_IMM: use_rd = 1'b1;
            rv_dec_pkg::OPC_OP: begin
                use2 = 1'b1;
                use_rd = 1'b1;
            end
            rv_dec_pkg::OPC_STORE, rv_dec_pkg::OPC_BRANCH: use2 = 1'b1;
            default: ;
        endcase
        ra1 = use1 ? inst[19:15] : 5'd0;
        ra2 = use2 ? inst[24:20] : 5'd0;
        re1 = (ra1 != 5'd0);
        re2 = (ra2 != 5'd0);
        wr = use_rd && (inst[11:7] != 5'd0);
        rda = wr ? inst[11:7] : 5'd0;
    endtask

    initial begin
        int unsigned cycles;
        int unsigned checked;
        void'($urandom(RAND_SEED));
        clk = 1'b0;
        reset_i = 1'b1;
        inst_i = '0;
        inst_addr_i = '0;
        inst_valid_i = 1'b0;
        cur_valid = 1'b0;
        {exp_valid, exp_ill, exp_we, exp_addr, exp_imm, exp_cls, exp_rd} = '0;
        exp_info = '0;

        cycles = 0;
        while (reset_i) begin
            @(posedge clk);
            cycles++;
            if (cycles == RESET_CYCLES) begin
                reset_i <= 1'b0;
            end
            @(negedge clk);
            check_value("valid_o", 32'd0, valid_o);
            check_value("reg_we_o", 32'd0, reg_we_o);
            check_value("illegal_o", 32'd0, illegal_o);
            if (cycles > 2 * RESET_CYCLES) begin
                abort_on_timeout("reset release");
            end
        end

        cycles = 0;
        checked = 0;
        while (checked < NUM_INSTS) begin
            @(posedge clk);
            // register model takes last cycle's word
            exp_valid = cur_valid;
            exp_ill = cur_valid && cur_ill;
            exp_we = cur_valid && !cur_ill && cur_wr;
            if (cur_valid) begin
                exp_addr = cur_addr;
                exp_info = cur_info;
                exp_cls = cur_cls;
                exp_imm = cur_imm;
                exp_rd = cur_rd;
            end
            cur_inst = random_inst();
            cur_addr = $urandom() & 32'hffff_fffc;
            cur_valid = ($urandom_range(99) < 80);
            decode_model(cur_inst, cur_info, cur_cls, cur_ill);
            cur_imm = imm_model(cur_inst);
            reg_model(cur_inst, cur_ra1, cur_ra2, cur_re1, cur_re2, cur_rd, cur_wr);
            inst_i <= cur_inst;
            inst_addr_i <= cur_addr;
            inst_valid_i <= cur_valid;

            @(negedge clk);
            check_value("reg1_raddr_o", cur_ra1, reg1_raddr_o); // same cycle
            check_value("reg2_raddr_o", cur_ra2, reg2_raddr_o);
            check_value("rs1_re_o", cur_re1, rs1_re_o);
            check_value("rs2_re_o", cur_re2, rs2_re_o);
            check_value("valid_o", exp_valid, valid_o);
            check_value("illegal_o", exp_ill, illegal_o);
            check_value("reg_we_o", exp_we, reg_we_o);
            check_value("inst_addr_o", exp_addr, inst_addr_o);
            check_value("info_o", exp_info, info_o);
            check_value("ex_class_o", exp_cls, ex_class_o);
            check_value("imm_o", exp_imm, imm_o);
            check_value("rd_waddr_o", exp_rd, rd_waddr_o);
            check_assertions();
            if (exp_valid) begin
                checked++;
            end
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_on_timeout("the full instruction count");
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: src.f
src/rv_dec_pkg.sv
src/inst_classify.sv
src/imm_gen.sv
src/reg_access.sv
src/id_ex_reg.sv
src/idu_top.sv
dv/idu_props.sv
dv/tb_idu.sv
